// File: hw/mips_pkg.sv
package mips_pkg;

    //////////////////////////////
    // Widths and field types
    //////////////////////////////

    // Data path word width
    localparam int WORD_W = 32;

    // Data or address word
    typedef logic [WORD_W-1:0] word_t;
    // Full instruction
    typedef logic [31:0] instr_t;
    // Opcode field, funct field shares the width
    typedef logic [5:0] opcode_t;
    // Register number
    typedef logic [4:0] reg_addr_t;
    // ALU operation class from main decoder
    typedef logic [1:0] alu_op_t;
    // ALU operation code
    typedef logic [3:0] alu_code_t;

    //////////////////////////////
    // Opcodes
    //////////////////////////////

    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_J     = 6'b000010;

    // R-type funct codes
    localparam opcode_t FN_ADD = 6'b100000;
    localparam opcode_t FN_SUB = 6'b100010;
    localparam opcode_t FN_AND = 6'b100100;
    localparam opcode_t FN_OR  = 6'b100101;
    localparam opcode_t FN_SLT = 6'b101010;

    // ALU operation classes
    localparam alu_op_t ALUOP_MEM    = 2'b00;
    localparam alu_op_t ALUOP_BRANCH = 2'b01;
    localparam alu_op_t ALUOP_RTYPE  = 2'b10;

    // ALU codes
    localparam alu_code_t ALU_AND = 4'b0000;
    localparam alu_code_t ALU_OR  = 4'b0001;
    localparam alu_code_t ALU_ADD = 4'b0010;
    localparam alu_code_t ALU_SUB = 4'b0110;
    localparam alu_code_t ALU_SLT = 4'b0111;

endpackage

// File: hw/ctrl_if.sv
`timescale 1ns/1ps

interface ctrl_if;
    import mips_pkg::*;

    // Destination select, rd when high
    logic      reg_dst;
    logic      jump;
    logic      branch;
    logic      mem_read;
    logic      mem_to_reg;
    logic      mem_write;
    // Immediate as ALU operand B
    logic      alu_src;
    logic      reg_write;
    alu_code_t alu_code;

    // Decoder side
    modport dec (
        output reg_dst, jump, branch, mem_read, mem_to_reg,
        output mem_write, alu_src, reg_write, alu_code
    );

    // Datapath side
    modport dp (
        input reg_dst, jump, branch, mem_read, mem_to_reg,
        input mem_write, alu_src, reg_write, alu_code
    );

endinterface

// File: hw/alu_control.sv
`timescale 1ns/1ps

module alu_control (
    input  mips_pkg::opcode_t   i_funct,
    input  mips_pkg::alu_op_t   i_alu_op,
    output mips_pkg::alu_code_t o_alu_code
);
    import mips_pkg::*;

    always_comb
    begin
        case (i_alu_op)
            // lw and sw address add
            ALUOP_MEM:    o_alu_code = ALU_ADD;
            // beq compares by subtraction
            ALUOP_BRANCH: o_alu_code = ALU_SUB;
            ALUOP_RTYPE:
            begin
                // Operation from funct field
                case (i_funct)
                    FN_ADD:  o_alu_code = ALU_ADD;
                    FN_SUB:  o_alu_code = ALU_SUB;
                    FN_AND:  o_alu_code = ALU_AND;
                    FN_OR:   o_alu_code = ALU_OR;
                    FN_SLT:  o_alu_code = ALU_SLT;
                    // Unsupported funct falls back to add
                    default: o_alu_code = ALU_ADD;
                endcase
            end
            default:      o_alu_code = ALU_ADD;
        endcase
    end

endmodule

// File: hw/control.sv
`timescale 1ns/1ps

module control (
    input  mips_pkg::opcode_t i_opcode,
    input  mips_pkg::opcode_t i_funct,
    ctrl_if.dec               o_ctrl
);
    import mips_pkg::*;

    // Class handed to the ALU decoder
    alu_op_t   alu_op;
    alu_code_t alu_code;

    //////////////////////////////
    // Main decoder
    //////////////////////////////

    always_comb
    begin
        // Unknown opcode behaves as a no-op
        alu_op            = ALUOP_MEM;
        o_ctrl.reg_dst    = 1'b0;
        o_ctrl.jump       = 1'b0;
        o_ctrl.branch     = 1'b0;
        o_ctrl.mem_read   = 1'b0;
        o_ctrl.mem_to_reg = 1'b0;
        o_ctrl.mem_write  = 1'b0;
        o_ctrl.alu_src    = 1'b0;
        o_ctrl.reg_write  = 1'b0;
        case (i_opcode)
            OP_RTYPE:
            begin
                // Write rd with the ALU result
                alu_op           = ALUOP_RTYPE;
                o_ctrl.reg_dst   = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            OP_LW:
            begin
                // Base plus offset, load into rt
                o_ctrl.alu_src    = 1'b1;
                o_ctrl.mem_read   = 1'b1;
                o_ctrl.mem_to_reg = 1'b1;
                o_ctrl.reg_write  = 1'b1;
            end
            OP_SW:
            begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.mem_write = 1'b1;
            end
            OP_BEQ:
            begin
                // Compare by subtraction
                alu_op        = ALUOP_BRANCH;
                o_ctrl.branch = 1'b1;
            end
            OP_J:
            begin
                o_ctrl.jump = 1'b1;
            end
            default:
            begin
                alu_op = ALUOP_MEM;
            end
        endcase
    end

    // ALU code from class and funct
    alu_control u_alu_control (
        .i_funct   (i_funct),
        .i_alu_op  (alu_op),
        .o_alu_code(alu_code)
    );

    assign o_ctrl.alu_code = alu_code;

    // Load and store never decoded together
    always_comb
    begin
        a_mem_excl: assert final (!(o_ctrl.mem_read && o_ctrl.mem_write));
    end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  mips_pkg::word_t     i_a,
    input  mips_pkg::word_t     i_b,
    input  mips_pkg::alu_code_t i_code,
    output mips_pkg::word_t     o_result,
    output logic                o_zero
);
    import mips_pkg::*;

    // Signed compare for slt
    logic lt_signed;

    assign lt_signed = $signed(i_a) < $signed(i_b);

    always_comb
    begin
        case (i_code)
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;
            // One in bit 0, rest cleared
            ALU_SLT: o_result = {{(WORD_W-1){1'b0}}, lt_signed};
            default: o_result = i_a + i_b;
        endcase
    end

    // Equal operands on beq give zero
    assign o_zero = (o_result == '0);

endmodule

// File: hw/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  mips_pkg::reg_addr_t i_rs,
    input  mips_pkg::reg_addr_t i_rt,
    input  mips_pkg::reg_addr_t i_wr_addr,
    input  logic                i_wr_en,
    input  mips_pkg::word_t     i_wr_data,
    output mips_pkg::word_t     o_rs_data,
    output mips_pkg::word_t     o_rt_data
);
    import mips_pkg::*;

    // 32 general registers
    word_t regs [32];

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        // r0 stays zero, writes dropped
        else if (i_wr_en && (i_wr_addr != '0))
        begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Read ports, old value on same-cycle write
    assign o_rs_data = regs[i_rs];
    assign o_rt_data = regs[i_rt];

endmodule

// File: hw/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
    parameter int DMEM_ADDR_W = 6
) (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  mips_pkg::word_t i_addr,
    input  logic            i_we,
    input  mips_pkg::word_t i_wdata,
    output mips_pkg::word_t o_rdata
);
    import mips_pkg::*;

    localparam int DEPTH = 1 << DMEM_ADDR_W;

    word_t                  mem [DEPTH];
    // Word index, byte offset and upper bits ignored
    logic [DMEM_ADDR_W-1:0] word_idx;

    assign word_idx = i_addr[DMEM_ADDR_W+1:2];

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (i_we)
        begin
            mem[word_idx] <= i_wdata;
        end
    end

    // Asynchronous read
    assign o_rdata = mem[word_idx];

endmodule

// File: hw/mips_datapath.sv
`timescale 1ns/1ps

module mips_datapath #(
    parameter int DMEM_ADDR_W = 6
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  mips_pkg::instr_t    i_instr,
    ctrl_if.dp                  i_ctrl,
    output mips_pkg::word_t     o_pc,
    output logic                o_wb_en,
    output mips_pkg::reg_addr_t o_wb_addr,
    output mips_pkg::word_t     o_wb_data,
    output logic                o_mem_we,
    output mips_pkg::word_t     o_mem_addr,
    output mips_pkg::word_t     o_mem_wdata
);
    import mips_pkg::*;

    word_t     pc_q;
    word_t     pc_plus4;
    word_t     pc_next;
    word_t     imm_ext;
    word_t     rs_data;
    word_t     rt_data;
    word_t     alu_b;
    word_t     alu_result;
    word_t     mem_rdata;
    word_t     load_data;
    logic      alu_zero;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;

    // Instruction fields
    assign rs      = i_instr[25:21];
    assign rt      = i_instr[20:16];
    assign rd      = i_instr[15:11];
    assign imm_ext = {{16{i_instr[15]}}, i_instr[15:0]};

    //////////////////////////////
    // Program counter
    //////////////////////////////

    assign pc_plus4 = pc_q + 32'd4;

    always_comb
    begin
        if (i_ctrl.jump)
        begin
            // Upper bits of PC+4 joined to the word target
            pc_next = {pc_plus4[31:28], i_instr[25:0], 2'b00};
        end
        else if (i_ctrl.branch && alu_zero)
        begin
            pc_next = pc_plus4 + {imm_ext[29:0], 2'b00};
        end
        else
        begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            pc_q <= '0;
        end
        else
        begin
            pc_q <= pc_next;
        end
    end

    //////////////////////////////
    // Execute and memory
    //////////////////////////////

    register_file u_register_file (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_rs     (rs),
        .i_rt     (rt),
        .i_wr_addr(o_wb_addr),
        .i_wr_en  (o_wb_en),
        .i_wr_data(o_wb_data),
        .o_rs_data(rs_data),
        .o_rt_data(rt_data)
    );

    // Operand B is rt or the immediate
    assign alu_b = i_ctrl.alu_src ? imm_ext : rt_data;

    alu u_alu (
        .i_a     (rs_data),
        .i_b     (alu_b),
        .i_code  (i_ctrl.alu_code),
        .o_result(alu_result),
        .o_zero  (alu_zero)
    );

    data_memory #(
        .DMEM_ADDR_W(DMEM_ADDR_W)
    ) u_data_memory (
        .i_clk  (i_clk),
        .i_rst_n(i_rst_n),
        .i_addr (alu_result),
        .i_we   (o_mem_we),
        .i_wdata(rt_data),
        .o_rdata(mem_rdata)
    );

    // Load bus idle outside loads
    assign load_data = i_ctrl.mem_read ? mem_rdata : '0;

    // Write-back and store events stay quiet in reset
    assign o_wb_en     = i_ctrl.reg_write & i_rst_n;
    assign o_wb_addr   = i_ctrl.reg_dst ? rd : rt;
    assign o_wb_data   = i_ctrl.mem_to_reg ? load_data : alu_result;
    assign o_mem_we    = i_ctrl.mem_write & i_rst_n;
    assign o_mem_addr  = alu_result;
    assign o_mem_wdata = rt_data;
    assign o_pc        = pc_q;

    // PC stays on a word boundary across jumps and branches
    a_pc_aligned: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) pc_q[1:0] == 2'b00
    );

endmodule

// File: hw/mips_core.sv
`timescale 1ns/1ps

module mips_core #(
    parameter int DMEM_ADDR_W = 6
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic [31:0] i_instr,
    output logic [31:0] o_pc,
    output logic        o_wb_en,
    output logic [4:0]  o_wb_addr,
    output logic [31:0] o_wb_data,
    output logic        o_mem_we,
    output logic [31:0] o_mem_addr,
    output logic [31:0] o_mem_wdata
);

    // Decoded controls, decoder to datapath
    ctrl_if u_ctrl ();

    //////////////////////////////
    // Decoder
    //////////////////////////////

    // Opcode and funct fields only
    control u_control (
        .i_opcode(i_instr[31:26]),
        .i_funct (i_instr[5:0]),
        .o_ctrl  (u_ctrl.dec)
    );

    //////////////////////////////
    // Datapath
    //////////////////////////////

    mips_datapath #(
        .DMEM_ADDR_W(DMEM_ADDR_W)
    ) u_mips_datapath (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_instr    (i_instr),
        .i_ctrl     (u_ctrl.dp),
        .o_pc       (o_pc),
        .o_wb_en    (o_wb_en),
        .o_wb_addr  (o_wb_addr),
        .o_wb_data  (o_wb_data),
        .o_mem_we   (o_mem_we),
        .o_mem_addr (o_mem_addr),
        .o_mem_wdata(o_mem_wdata)
    );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic o_clk,
    output logic o_rst_n
);

    // 4 ns period
    initial
    begin
        o_clk = 1'b0;
        forever
        begin
            #2 o_clk = ~o_clk;
        end
    end

    // Reset low for 16 cycles, released just after an edge
    initial
    begin
        o_rst_n = 1'b0;
        repeat (16) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

// File: test/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

    //////////////////////////////
    // Encodings and run length
    //////////////////////////////

    // MIPS32 opcodes
    localparam logic [5:0] OPC_RTYPE = 6'b000000;
    localparam logic [5:0] OPC_LW    = 6'b100011;
    localparam logic [5:0] OPC_SW    = 6'b101011;
    localparam logic [5:0] OPC_BEQ   = 6'b000100;
    localparam logic [5:0] OPC_J     = 6'b000010;
    // R-type funct codes
    localparam logic [5:0] FUNCT_ADD = 6'b100000;
    localparam logic [5:0] FUNCT_SUB = 6'b100010;
    localparam logic [5:0] FUNCT_AND = 6'b100100;
    localparam logic [5:0] FUNCT_OR  = 6'b100101;
    localparam logic [5:0] FUNCT_SLT = 6'b101010;

    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // Cycles per test
    localparam int N_RESET = 16;
    localparam int N_SEED  = 7;
    localparam int N_RTYPE = 300;
    localparam int N_MEM   = 64;
    localparam int N_BR    = 60;
    localparam int N_UNK   = 8;
    localparam int N_MIX   = 500;
    localparam int N_TOTAL = N_RESET + N_SEED + N_RTYPE + N_MEM + N_BR + N_UNK + N_MIX;
    localparam int TIMEOUT_CYCLES = N_TOTAL * 3 / 2;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] o_pc;
    logic        o_wb_en;
    logic [4:0]  o_wb_addr;
    logic [31:0] o_wb_data;
    logic        o_mem_we;
    logic [31:0] o_mem_addr;
    logic [31:0] o_mem_wdata;

    // Architectural state of the model
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [64];
    logic [31:0] model_pc;

    logic [31:0] lfsr;
    logic [31:0] seed_data;
    logic        seeding;
    logic        was_reset;
    int          error_count;
    int          check_count;
    int          test_count;
    int          cycle_count;

    tb_clock u_clock (
        .o_clk  (clk),
        .o_rst_n(rst_n)
    );

    mips_core #(
        .DMEM_ADDR_W(6)
    ) dut0 (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_instr    (instr),
        .o_pc       (o_pc),
        .o_wb_en    (o_wb_en),
        .o_wb_addr  (o_wb_addr),
        .o_wb_data  (o_wb_data),
        .o_mem_we   (o_mem_we),
        .o_mem_addr (o_mem_addr),
        .o_mem_wdata(o_mem_wdata)
    );

    //////////////////////////////
    // Random instructions
    //////////////////////////////

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Registers r0 to r7 only
    function automatic logic [31:0] rtype_instr();
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [5:0] fn;
        rs = 5'(rand_bits(3));
        rt = 5'(rand_bits(3));
        rd = 5'(rand_bits(3));
        case (rand_bits(3) % 5)
            0:       fn = FUNCT_ADD;
            1:       fn = FUNCT_SUB;
            2:       fn = FUNCT_AND;
            3:       fn = FUNCT_OR;
            default: fn = FUNCT_SLT;
        endcase
        return {OPC_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    // Base r0 and a word offset below 256
    function automatic logic [31:0] mem_instr(input logic [5:0] op);
        logic [4:0]  rt;
        logic [15:0] off;
        rt  = 5'(rand_bits(3));
        off = 16'(rand_bits(6) << 2);
        return {op, 5'd0, rt, off};
    endfunction

    // Small signed offset with equal operands half the time
    function automatic logic [31:0] branch_instr();
        logic [4:0] rs;
        logic [4:0] rt;
        logic [3:0] off;
        rs = 5'(rand_bits(3));
        rt = 5'(rand_bits(3));
        if (rand_bits(1) != 0)
        begin
            rt = rs;
        end
        off = 4'(rand_bits(4));
        return {OPC_BEQ, rs, rt, {{12{off[3]}}, off}};
    endfunction

    // Target inside 4 KB
    function automatic logic [31:0] jump_instr();
        return {OPC_J, 16'd0, 10'(rand_bits(10))};
    endfunction

    function automatic logic [31:0] unknown_instr();
        logic [5:0] op;
        case (rand_bits(2))
            0:       op = 6'h08;
            1:       op = 6'h0c;
            2:       op = 6'h0f;
            default: op = 6'h20;
        endcase
        return {op, 26'(rand_bits(26))};
    endfunction

    function automatic logic [31:0] mixed_instr();
        case (rand_bits(3))
            0, 1, 2: return rtype_instr();
            3:       return mem_instr(OPC_LW);
            4:       return mem_instr(OPC_SW);
            5:       return branch_instr();
            6:       return jump_instr();
            default: return unknown_instr();
        endcase
    endfunction

    //////////////////////////////
    // Model and checks
    //////////////////////////////

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string name);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Expected outputs for one instruction and the state update
    task automatic check_cycle(input logic [31:0] ins);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] pc4;
        logic [31:0] next_pc;
        logic        exp_wb_en;
        logic        exp_mem_we;
        op   = ins[31:26];
        fn   = ins[5:0];
        rs   = ins[25:21];
        rt   = ins[20:16];
        rd   = ins[15:11];
        a    = model_regs[rs];
        b    = model_regs[rt];
        imm  = {{16{ins[15]}}, ins[15:0]};
        addr = a + imm;
        pc4  = model_pc + 32'd4;
        next_pc    = pc4;
        exp_wb_en  = (op == OPC_RTYPE) || (op == OPC_LW);
        exp_mem_we = (op == OPC_SW);
        compare(o_pc, model_pc, "o_pc");
        compare({31'd0, o_wb_en}, {31'd0, exp_wb_en}, "o_wb_en");
        compare({31'd0, o_mem_we}, {31'd0, exp_mem_we}, "o_mem_we");
        case (op)
            OPC_RTYPE:
            begin
                case (fn)
                    FUNCT_SUB: res = a - b;
                    FUNCT_AND: res = a & b;
                    FUNCT_OR:  res = a | b;
                    FUNCT_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:   res = a + b;
                endcase
                // Write-back data is forced while seeding
                if (seeding)
                begin
                    res = seed_data;
                end
                else
                begin
                    compare(o_wb_data, res, "o_wb_data");
                end
                compare({27'd0, o_wb_addr}, {27'd0, rd}, "o_wb_addr");
                if (rd != 5'd0)
                begin
                    model_regs[rd] = res;
                end
            end
            OPC_LW:
            begin
                // Word index from address bits 7:2
                res = model_mem[addr[7:2]];
                compare(o_mem_addr, addr, "o_mem_addr");
                compare({27'd0, o_wb_addr}, {27'd0, rt}, "o_wb_addr");
                compare(o_wb_data, res, "o_wb_data");
                if (rt != 5'd0)
                begin
                    model_regs[rt] = res;
                end
            end
            OPC_SW:
            begin
                compare(o_mem_addr, addr, "o_mem_addr");
                compare(o_mem_wdata, b, "o_mem_wdata");
                model_mem[addr[7:2]] = b;
            end
            OPC_BEQ:
            begin
                if (a == b)
                begin
                    next_pc = pc4 + {imm[29:0], 2'b00};
                end
            end
            OPC_J:
            begin
                next_pc = {pc4[31:28], ins[25:0], 2'b00};
            end
            default:
            begin
                // No-op advances the PC only
                next_pc = pc4;
            end
        endcase
        model_pc = next_pc;
    endtask

    // Entered 1 ns after an edge and returns 1 ns after the next one
    task automatic step(input logic [31:0] ins);
        instr = ins;
        #2;
        if (!rst_n)
        begin
            // Quiet outputs while held in reset
            compare(o_pc, 32'd0, "o_pc");
            compare({31'd0, o_wb_en}, 32'd0, "o_wb_en");
            compare({31'd0, o_mem_we}, 32'd0, "o_mem_we");
            was_reset = 1'b1;
        end
        else
        begin
            check_cycle(ins);
            was_reset = 1'b0;
        end
        @(posedge clk);
        #1;
    endtask

    // Give r1 to r7 random values through the write-back bus
    task automatic seed_registers();
        seeding = 1'b1;
        for (int r = 1; r < 8; r++)
        begin
            seed_data = rand_bits(32);
            force dut0.u_mips_datapath.o_wb_data = seed_data;
            step({OPC_RTYPE, 5'd0, 5'd0, 5'(r), 5'd0, FUNCT_ADD});
            release dut0.u_mips_datapath.o_wb_data;
        end
        seeding = 1'b0;
    endtask

    task automatic report(input string name, input int errs_before, input int checks_before);
        test_count++;
        $display("%-8s finished: %0d checks, %0d errors", name,
                 check_count - checks_before, error_count - errs_before);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial
    begin
        int e0;
        int c0;
        instr       = '0;
        lfsr        = 32'he25f_20af;
        seed_data   = '0;
        seeding     = 1'b0;
        was_reset   = 1'b1;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        cycle_count = 0;
        model_pc    = '0;
        for (int i = 0; i < 32; i++)
        begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 64; i++)
        begin
            model_mem[i] = '0;
        end
        @(posedge clk);
        #1;

        // Reset phase ends with the first cycle after release
        e0 = error_count;
        c0 = check_count;
        while (was_reset)
        begin
            step(mixed_instr());
        end
        report("reset", e0, c0);

        e0 = error_count;
        c0 = check_count;
        seed_registers();
        report("seed", e0, c0);

        e0 = error_count;
        c0 = check_count;
        repeat (N_RTYPE) step(rtype_instr());
        report("rtype", e0, c0);

        // Stores first and loads after
        e0 = error_count;
        c0 = check_count;
        repeat (N_MEM / 2) step(mem_instr(OPC_SW));
        repeat (N_MEM / 2) step(mem_instr(OPC_LW));
        report("memory", e0, c0);

        e0 = error_count;
        c0 = check_count;
        repeat (N_BR / 2)
        begin
            step(branch_instr());
            step(jump_instr());
        end
        report("branch", e0, c0);

        e0 = error_count;
        c0 = check_count;
        repeat (N_UNK) step(unknown_instr());
        report("unknown", e0, c0);

        e0 = error_count;
        c0 = check_count;
        repeat (N_MIX) step(mixed_instr());
        // PC after the last instruction
        #2;
        compare(o_pc, model_pc, "o_pc");
        report("mixed", e0, c0);

        $display("Done: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog on total cycles
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

endmodule

// File: tb.f
hw/mips_pkg.sv
hw/ctrl_if.sv
hw/alu_control.sv
hw/control.sv
hw/alu.sv
hw/register_file.sv
hw/data_memory.sv
hw/mips_datapath.sv
hw/mips_core.sv
test/tb_clock.sv
test/tb_mips_core.sv
